/* hdl/cd_rx_pkg.sv */
// shared types and constants for the rx byte stage; pages are fixed at 256 bytes by the length field
package cd_rx_pkg;

    typedef logic [7:0]  byte_t;      // bus byte, data or address
    typedef logic [8:0]  frame_len_t; // stored byte count, up to 260
    typedef logic [15:0] crc_t;       // crc register

    // parser states
    typedef enum logic {
        idle_wait,
        data
    } rx_state_t;

    // frame layout: src, dst, len, [data], crc_l, crc_h
    localparam frame_len_t HDR_LEN      = 9'd3;
    localparam frame_len_t CRC_LEN      = 9'd2;
    localparam byte_t      MAX_DATA_LEN = 8'd253;

    localparam byte_t ADDR_BROADCAST = 8'hff; // also the promiscuous filter value

    // crc-16 modbus, reflected
    localparam crc_t CRC_INIT = 16'hffff;
    localparam crc_t CRC_POLY = 16'ha001;

endpackage

/* hdl/cd_rx_crc.sv */
// crc-16 modbus over the byte stream; crc_eq_zero is only meaningful while des_data_clk is high
`timescale 1ns/1ps

module cd_rx_crc
    import cd_rx_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  byte_t des_data,
    input  logic  des_data_clk,
    input  logic  des_bus_idle,
    output logic  crc_eq_zero
);

    crc_t crc_q;
    crc_t crc_nxt;

    // one byte, lsb first
    function automatic crc_t crc_step(crc_t c, byte_t d);
        crc_t r;
        r = c ^ {8'h00, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    assign crc_nxt     = crc_step(crc_q, des_data);
    assign crc_eq_zero = (crc_nxt == 16'h0000); // residue including current byte

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc_q <= CRC_INIT;
        end else if (des_bus_idle) begin
            crc_q <= CRC_INIT; // restart for next frame
        end else if (des_data_clk) begin
            crc_q <= crc_nxt;
        end
    end

endmodule

/* hdl/cd_rx_bytes.sv */
// frame parser and address filter; config inputs must stay stable during a frame, only 256 bytes are stored
`timescale 1ns/1ps

module cd_rx_bytes
    import cd_rx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  byte_t      filter,
    input  byte_t      filter_m0,
    input  byte_t      filter_m1,
    input  logic       user_crc,
    input  logic       not_drop,
    input  logic       abort,

    input  logic       des_bus_idle,
    input  logic       des_data_clk,
    input  logic       crc_eq_zero,
    input  byte_t      des_data,

    output logic       error,

    output byte_t      ram_wr_byte,
    output byte_t      ram_wr_addr,
    output logic       ram_wr_en,
    output frame_len_t ram_wr_len,
    output logic       ram_switch
);

    rx_state_t  state;
    frame_len_t byte_cnt;  // bytes seen in this frame
    byte_t      data_len;  // copy of byte 2
    logic       drop_flag;

    logic       is_promisc;
    logic       dst_match;
    logic       byte_stb;
    logic       is_last;
    logic       frame_good;
    frame_len_t last_idx;

    // clamp to one page
    function automatic frame_len_t clamp_len(frame_len_t n);
        if (n > 9'd256)
            return 9'd256;
        return n;
    endfunction

    assign is_promisc = (filter == ADDR_BROADCAST);
    assign dst_match  = (des_data == filter) || (des_data == ADDR_BROADCAST) ||
                        (des_data == filter_m0) || (des_data == filter_m1);

    assign byte_stb   = (state == data) && des_data_clk && !des_bus_idle;
    assign last_idx   = frame_len_t'(data_len) + HDR_LEN + CRC_LEN - 9'd1;
    assign is_last    = byte_stb && (byte_cnt == last_idx);
    assign frame_good = (crc_eq_zero || user_crc) && (data_len <= MAX_DATA_LEN);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle_wait;
            byte_cnt   <= '0;
            data_len   <= '0;
            drop_flag  <= 1'b0;
            error      <= 1'b0;
            ram_wr_en  <= 1'b0;
            ram_switch <= 1'b0;
        end else begin
            error      <= 1'b0;
            ram_switch <= 1'b0;
            ram_wr_en  <= byte_stb && !byte_cnt[8]; // first 256 bytes only

            case (state)
                idle_wait: begin
                    byte_cnt  <= '0;
                    data_len  <= '0;
                    drop_flag <= 1'b0;
                    if (des_bus_idle)
                        state <= data; // bus quiet, ready for a frame
                end

                data: begin
                    if (des_bus_idle) begin
                        if (byte_cnt != '0) begin
                            // cut short by idle
                            if (!drop_flag && !abort) begin
                                error      <= 1'b1;
                                ram_switch <= not_drop;
                            end
                            state <= idle_wait;
                        end
                    end else if (byte_stb) begin
                        byte_cnt <= byte_cnt + 9'd1;

                        if (byte_cnt == 9'd0 && des_data == filter)
                            drop_flag <= !is_promisc; // own echo
                        if (byte_cnt == 9'd1 && !dst_match)
                            drop_flag <= !is_promisc;
                        if (byte_cnt == 9'd2)
                            data_len <= des_data;

                        if (is_last) begin
                            if (!drop_flag && !abort) begin
                                if (frame_good) begin
                                    ram_switch <= 1'b1;
                                end else begin
                                    error      <= 1'b1;
                                    ram_switch <= not_drop;
                                end
                            end
                            state <= idle_wait;
                        end
                    end
                end

                default: state <= idle_wait;
            endcase

            if (abort)
                state <= idle_wait; // skip rest of frame until idle
        end
    end

    // payload side of the write port
    always_ff @(posedge clk) begin
        if (byte_stb) begin
            ram_wr_byte <= des_data;
            ram_wr_addr <= byte_cnt[7:0];
        end
        if (is_last)
            ram_wr_len <= clamp_len(byte_cnt + 9'd1);
        else if (state == data && des_bus_idle)
            ram_wr_len <= clamp_len(byte_cnt); // bytes actually received
    end

endmodule

/* hdl/cd_rx_pp_buf.sv */
// two 256-byte pages, one frame pending at a time; every out_valid byte must be taken by the consumer
`timescale 1ns/1ps

module cd_rx_pp_buf
    import cd_rx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    input  byte_t      ram_wr_byte,
    input  byte_t      ram_wr_addr,
    input  logic       ram_wr_en,
    input  frame_len_t ram_wr_len,
    input  logic       ram_switch,

    input  logic       rd_credit,

    output byte_t      out_data,
    output logic       out_valid,
    output logic       out_last,
    output logic       rx_lost
);

    byte_t      mem [0:511];  // page is the msb of the index
    frame_len_t page_len [0:1];
    logic [1:0] full;
    logic       wr_page;
    logic       rd_page;
    byte_t      rd_addr;
    logic [9:0] credit_cnt;

    logic       commit_ok;
    logic       take;
    logic       take_last;

    assign commit_ok = ram_switch && !full[~wr_page];
    assign take      = (credit_cnt != '0) && full[rd_page];
    assign take_last = take && (frame_len_t'(rd_addr) == page_len[rd_page] - 9'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            full       <= 2'b00;
            wr_page    <= 1'b0;
            rd_page    <= 1'b0;
            rd_addr    <= '0;
            credit_cnt <= '0;
            out_valid  <= 1'b0;
            out_last   <= 1'b0;
            rx_lost    <= 1'b0;
        end else begin
            out_valid <= take;
            out_last  <= take_last;
            rx_lost   <= ram_switch && full[~wr_page]; // no room, frame thrown away

            if (commit_ok) begin
                full[wr_page] <= 1'b1;
                wr_page       <= ~wr_page;
            end

            if (take) begin
                rd_addr <= rd_addr + 8'd1;
                if (take_last) begin
                    rd_addr       <= '0;
                    full[rd_page] <= 1'b0; // page free again
                    rd_page       <= ~rd_page;
                end
            end

            case ({rd_credit, take})
                2'b10: if (credit_cnt != '1) credit_cnt <= credit_cnt + 10'd1;
                2'b01: credit_cnt <= credit_cnt - 10'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ram_wr_en)
            mem[{wr_page, ram_wr_addr}] <= ram_wr_byte;
        if (commit_ok)
            page_len[wr_page] <= ram_wr_len;
        out_data <= mem[{rd_page, rd_addr}];
    end

endmodule

/* hdl/cd_rx_top.sv */
// rx byte stage top; bytes arrive already deserialized and config ports are plain inputs
`timescale 1ns/1ps

module cd_rx_top
    import cd_rx_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,

    input  byte_t des_data,
    input  logic  des_data_clk,
    input  logic  des_bus_idle,

    input  byte_t filter,
    input  byte_t filter_m0,
    input  byte_t filter_m1,
    input  logic  user_crc,
    input  logic  not_drop,
    input  logic  abort,

    input  logic  rd_credit,
    output byte_t out_data,
    output logic  out_valid,
    output logic  out_last,

    output logic  error,
    output logic  rx_lost
);

    logic       crc_eq_zero;
    byte_t      ram_wr_byte;
    byte_t      ram_wr_addr;
    logic       ram_wr_en;
    frame_len_t ram_wr_len;
    logic       ram_switch;

    cd_rx_crc i_crc (
        .clk          (clk),
        .reset_n      (reset_n),
        .des_data     (des_data),
        .des_data_clk (des_data_clk),
        .des_bus_idle (des_bus_idle),
        .crc_eq_zero  (crc_eq_zero)
    );

    cd_rx_bytes i_bytes (
        .clk          (clk),
        .reset_n      (reset_n),
        .filter       (filter),
        .filter_m0    (filter_m0),
        .filter_m1    (filter_m1),
        .user_crc     (user_crc),
        .not_drop     (not_drop),
        .abort        (abort),
        .des_bus_idle (des_bus_idle),
        .des_data_clk (des_data_clk),
        .crc_eq_zero  (crc_eq_zero),
        .des_data     (des_data),
        .error        (error),
        .ram_wr_byte  (ram_wr_byte),
        .ram_wr_addr  (ram_wr_addr),
        .ram_wr_en    (ram_wr_en),
        .ram_wr_len   (ram_wr_len),
        .ram_switch   (ram_switch)
    );

    cd_rx_pp_buf i_buf (
        .clk         (clk),
        .reset_n     (reset_n),
        .ram_wr_byte (ram_wr_byte),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_len  (ram_wr_len),
        .ram_switch  (ram_switch),
        .rd_credit   (rd_credit),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_last    (out_last),
        .rx_lost     (rx_lost)
    );

endmodule

/* verif/cd_rx_props.sv */
// bound into the buffer and the parser; unused inputs of each binding are tied off
`timescale 1ns/1ps

module cd_rx_props (
    input logic clk,
    input logic reset_n,
    input logic rd_credit,
    input logic out_valid,
    input logic out_last,
    input logic ram_switch,
    input logic error,
    input logic not_drop
);

    int credit_bal; // credits granted minus bytes delivered, seen at the ports

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            credit_bal <= 0;
        else
            credit_bal <= credit_bal + int'(rd_credit) - int'(out_valid);
    end

    // a byte goes out only against a credit granted before it
    a_credit: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> credit_bal > 0)
        else $error("out_valid without a credit");

    a_keep_bad: assert property (@(posedge clk) disable iff (!reset_n)
        (ram_switch && error) |-> not_drop)
        else $error("bad frame committed without not_drop");

    a_last: assert property (@(posedge clk) disable iff (!reset_n)
        out_last |-> out_valid)
        else $error("out_last outside out_valid");

endmodule

bind cd_rx_pp_buf cd_rx_props i_props_buf (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_credit  (rd_credit),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .ram_switch (1'b0),
    .error      (1'b0),
    .not_drop   (1'b1)
);

bind cd_rx_bytes cd_rx_props i_props_bytes (
    .clk        (clk),
    .reset_n    (reset_n),
    .rd_credit  (1'b0),
    .out_valid  (1'b0),
    .out_last   (1'b0),
    .ram_switch (ram_switch),
    .error      (error),
    .not_drop   (not_drop)
);

/* verif/cd_rx_checker.sv */
// compares delivered bytes and pulses with verif/cd_rx_cases.txt; frames longer than 256 bytes are cut
`timescale 1ns/1ps

module cd_rx_checker
    import cd_rx_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  byte_t out_data,
    input  logic  out_valid,
    input  logic  out_last,
    input  logic  error,
    input  logic  rx_lost,
    input  int    case_idx
);

    int    n_cases;
    int    exp_err [0:31];
    int    exp_lost [0:31];
    int    err_cnt [0:31];
    int    lost_cnt [0:31];
    int    mismatches;
    byte_t exp_q [$];
    bit    last_q [$];

    initial begin
        int    fd;
        int    r;
        int    v;
        int    n;
        int    deliv;
        byte_t fb [0:31];
        string line;
        n_cases    = 0;
        mismatches = 0;
        fd = $fopen("verif/cd_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the case file");
            mismatches++;
        end else begin
            while (n_cases == 0 && !$feof(fd)) begin
                r = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#")
                    r = $sscanf(line, "%d", n_cases);
            end
            for (int c = 0; c < n_cases; c++) begin
                for (int k = 0; k < 6; k++)
                    r = $fscanf(fd, " %h", v); // config is the stimulus side
                r = $fscanf(fd, " %d", n);
                for (int k = 0; k < n; k++) begin
                    r = $fscanf(fd, " %h", v);
                    fb[k] = byte_t'(v);
                end
                r = $fscanf(fd, " %h %h %h", exp_err[c], deliv, exp_lost[c]);
                if (n > 256)
                    n = 256;   // one page at most
                for (int k = 0; k < n && deliv != 0; k++) begin
                    exp_q.push_back(fb[k]);
                    last_q.push_back(k == n - 1);
                end
            end
            $fclose(fd);
        end
    end

    always @(negedge clk) begin
        if (reset_n) begin
            if (error)
                err_cnt[case_idx]++;
            if (rx_lost)
                lost_cnt[case_idx]++;
            if (out_last && !out_valid) begin
                $display("ERROR %0t: out_last without out_valid", $time);
                mismatches++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR %0t: unexpected byte %h delivered", $time, out_data);
                    mismatches++;
                end else begin
                    if (out_data !== exp_q[0] || out_last !== last_q[0]) begin
                        $display("ERROR %0t: got byte %h last %b, expected %h last %b",
                                 $time, out_data, out_last, exp_q[0], last_q[0]);
                        mismatches++;
                    end
                    void'(exp_q.pop_front());
                    void'(last_q.pop_front());
                end
            end
        end
    end

    task automatic final_check(output int total);
        for (int c = 0; c < n_cases; c++) begin
            if (err_cnt[c] != exp_err[c]) begin
                $display("ERROR %0t: case %0d gave %0d error pulses, expected %0d",
                         $time, c, err_cnt[c], exp_err[c]);
                mismatches++;
            end
            if (lost_cnt[c] != exp_lost[c]) begin
                $display("ERROR %0t: case %0d gave %0d lost pulses, expected %0d",
                         $time, c, lost_cnt[c], exp_lost[c]);
                mismatches++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected bytes were never delivered", exp_q.size());
            mismatches++;
        end
        total = mismatches;
    endtask

endmodule

/* verif/cd_rx_tb.sv */
// testbench top; needs verif/cd_rx_cases.txt relative to the run directory, at most 32 cases of 32 bytes
`timescale 1ns/1ps

module cd_rx_tb
    import cd_rx_pkg::*;
();

    logic   clk;
    logic   reset_n;
    byte_t  des_data;
    logic   des_data_clk;
    logic   des_bus_idle;
    byte_t  filter;
    byte_t  filter_m0;
    byte_t  filter_m1;
    logic   user_crc;
    logic   not_drop;
    logic   abort;
    logic   rd_credit;
    byte_t  out_data;
    logic   out_valid;
    logic   out_last;
    logic   error;
    logic   rx_lost;

    int     n_cases;
    int     case_idx;
    int     cfg [0:31][0:5];     // filter, m0, m1, user_crc, not_drop, wait_read
    int     nbytes [0:31];
    byte_t  frame [0:31][0:31];
    int     exp_flags [0:31][0:2]; // error, delivered, lost

    integer seed;
    logic   credit_en;
    int     credits_given;
    int     valid_seen;
    int     frames_done;
    int     frames_expected;
    int     cycles;
    int     cycle_limit;
    int     chk_errs;

    cd_rx_top i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .des_data     (des_data),
        .des_data_clk (des_data_clk),
        .des_bus_idle (des_bus_idle),
        .filter       (filter),
        .filter_m0    (filter_m0),
        .filter_m1    (filter_m1),
        .user_crc     (user_crc),
        .not_drop     (not_drop),
        .abort        (abort),
        .rd_credit    (rd_credit),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .error        (error),
        .rx_lost      (rx_lost)
    );

    cd_rx_checker i_chk (
        .clk       (clk),
        .reset_n   (reset_n),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .error     (error),
        .rx_lost   (rx_lost),
        .case_idx  (case_idx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles, not all cases finished", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // credit source, at most one credit banked at a time
    always @(negedge clk) begin
        if (!reset_n) begin
            rd_credit = 1'b0;
        end else begin
            if (out_valid)
                valid_seen++;
            if (out_last)
                frames_done++;
            if (credit_en && credits_given == valid_seen && ($random(seed) & 3) == 0) begin
                rd_credit = 1'b1;
                credits_given++;
            end else begin
                rd_credit = 1'b0;
            end
        end
    end

    task automatic load_cases();
        int    fd;
        int    r;
        int    v;
        string line;
        n_cases = 0;
        fd = $fopen("verif/cd_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file, nothing was run");
            return;
        end
        while (n_cases == 0 && !$feof(fd)) begin
            r = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#")
                r = $sscanf(line, "%d", n_cases);
        end
        for (int c = 0; c < n_cases; c++) begin
            for (int k = 0; k < 6; k++)
                r = $fscanf(fd, " %h", cfg[c][k]);
            r = $fscanf(fd, " %d", nbytes[c]);
            for (int k = 0; k < nbytes[c]; k++) begin
                r = $fscanf(fd, " %h", v);
                frame[c][k] = byte_t'(v);
            end
            for (int k = 0; k < 3; k++)
                r = $fscanf(fd, " %h", exp_flags[c][k]);
        end
        $fclose(fd);
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge clk);
        des_bus_idle = 1'b0;
        des_data     = b;
        des_data_clk = 1'b1;
        @(negedge clk);
        des_data_clk = 1'b0; // one quiet cycle between bytes
    endtask

    task automatic wait_frames(input int target);
        while (frames_done < target)
            @(posedge clk);
    endtask

    task automatic run_case(input int c);
        case_idx  = c;
        credit_en = (cfg[c][5] != 0); // stall the reader for back to back frames
        if (credit_en)
            wait_frames(frames_expected);
        @(negedge clk);
        filter    = byte_t'(cfg[c][0]);
        filter_m0 = byte_t'(cfg[c][1]);
        filter_m1 = byte_t'(cfg[c][2]);
        user_crc  = cfg[c][3][0];
        not_drop  = cfg[c][4][0];
        for (int k = 0; k < nbytes[c]; k++)
            send_byte(frame[c][k]);
        repeat (4) begin
            @(negedge clk);
            des_bus_idle = 1'b1;
        end
        frames_expected += exp_flags[c][1];
        if (credit_en)
            wait_frames(frames_expected);
    endtask

    initial begin
        reset_n         = 1'b0;
        des_data        = '0;
        des_data_clk    = 1'b0;
        des_bus_idle    = 1'b1;
        filter          = '0;
        filter_m0       = '0;
        filter_m1       = '0;
        user_crc        = 1'b0;
        not_drop        = 1'b0;
        abort           = 1'b0;
        rd_credit       = 1'b0;
        seed            = 32'hfb00;
        credit_en       = 1'b1;
        credits_given   = 0;
        valid_seen      = 0;
        frames_done     = 0;
        frames_expected = 0;
        cycles          = 0;
        case_idx        = 0;
        chk_errs        = 0;
        load_cases();
        cycle_limit = 400 * n_cases + 100;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);
        for (int c = 0; c < n_cases; c++)
            run_case(c);
        repeat (20) @(negedge clk);
        i_chk.final_check(chk_errs);
        if (n_cases == 0)
            chk_errs++;
        $display("cases %0d, frames delivered %0d, errors %0d", n_cases, frames_done, chk_errs);
        if (chk_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* verif/cd_rx_cases.txt */
# columns: filter m0 m1 user_crc not_drop wait_read count(dec) bytes(hex) ... exp_error exp_delivered exp_lost
# first non-comment line is the case count
15
03 10 11 0 0 1 7 01 03 02 00 01 79 84 0 1 0
05 10 11 0 0 1 7 01 ff 02 00 01 49 d4 0 1 0
05 03 11 0 0 1 7 01 03 02 00 01 79 84 0 1 0
05 10 03 0 0 1 7 01 03 02 00 01 79 84 0 1 0
05 10 11 0 0 1 7 01 03 02 00 01 79 84 0 0 0
01 03 11 0 0 1 7 01 03 02 00 01 79 84 0 0 0
ff 10 11 0 0 1 7 01 03 02 00 01 79 84 0 1 0
03 10 11 0 0 1 7 01 03 02 00 01 79 85 1 0 0
03 10 11 1 0 1 7 01 03 02 00 01 79 85 0 1 0
03 10 11 0 1 1 7 01 03 02 00 01 79 85 1 1 0
03 10 11 0 0 1 4 01 03 02 00 1 0 0
03 10 11 0 1 1 4 01 03 02 00 1 1 0
03 10 11 0 0 0 7 01 03 02 00 01 79 84 0 1 0
03 10 11 0 0 0 7 01 03 02 00 01 79 84 0 0 1
03 10 11 0 0 1 7 01 03 02 00 01 79 84 0 1 0

/* list.f */
hdl/cd_rx_pkg.sv
hdl/cd_rx_crc.sv
hdl/cd_rx_bytes.sv
hdl/cd_rx_pp_buf.sv
hdl/cd_rx_top.sv
verif/cd_rx_props.sv
verif/cd_rx_checker.sv
verif/cd_rx_tb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module cd_rx_tb -f list.f -o cd_rx_sim \
    > build.log 2>&1 \
    && ./obj_dir/cd_rx_sim > sim.log 2>&1 \
    && ! grep -q "Done: errors found" sim.log \
    && grep -q "Done: no errors" sim.log \
    && echo "PASS" \
    || { tail -n 40 build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
